// File: hdl/rv32i_types.sv
`default_nettype none

package rv32i_types;

    // fetch and memory geometry
    localparam logic [31:0] RESET_PC = 32'haaaaa000;
    localparam int IQ_DEPTH         = 8;
    localparam int ICACHE_SETS      = 8;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_OFFSET_BITS = 5;

    // derived widths
    localparam int IQ_PTR_BITS    = $clog2(IQ_DEPTH);
    localparam int SET_IDX_BITS   = $clog2(ICACHE_SETS);
    localparam int TAG_BITS       = 32 - LINE_OFFSET_BITS - SET_IDX_BITS;
    localparam int BEAT_IDX_BITS  = $clog2(BEATS_PER_LINE);
    // 8 bytes per memory beat
    localparam int BEAT_BYTE_BITS = 3;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [63:0]  order_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;
    typedef logic [4:0]   reg_idx_t;

    typedef logic [IQ_PTR_BITS-1:0]   iq_ptr_t;
    typedef logic [SET_IDX_BITS-1:0]  set_idx_t;
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

    // rv32i major opcodes
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [1:0] {
        class_alu,
        class_br,
        class_mem,
        class_none
    } op_class_e;

    // queue entry
    typedef struct packed {
        order_t order;
        addr_t  pc;
        word_t  inst;
    } fetch_pkt_t;

    typedef struct packed {
        order_t    order;
        addr_t     pc;
        word_t     inst;
        op_class_e op_class;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        word_t     imm;
        logic      rd_we;
    } decoded_pkt_t;

endpackage

`default_nettype wire

// File: hdl/fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       redirect_i,
    input  addr_t      redirect_pc_i,

    input  logic       resp_i,
    input  line_t      resp_line_i,
    output logic       req_o,
    output addr_t      req_addr_o,

    input  logic       iq_full_i,
    output logic       enq_o,
    output fetch_pkt_t enq_pkt_o,
    output logic       flush_o
);

    typedef enum logic {
        IDLE,
        WAIT_RESP
    } fetch_state_e;

    fetch_state_e state;

    addr_t  pc;
    order_t order;

    // one-line buffer of the last cache response
    logic   lb_valid;
    addr_t  lb_addr;
    line_t  lb_line;

    logic   lb_hit;
    logic   resp_hit;
    line_t  cur_line;
    word_t  cur_word;

    assign lb_hit = lb_valid &&
        (pc[31:LINE_OFFSET_BITS] == lb_addr[31:LINE_OFFSET_BITS]);

    // a late response after redirect only counts if it covers the new pc
    assign resp_hit = (state == WAIT_RESP) && resp_i &&
        (req_addr_o[31:LINE_OFFSET_BITS] == pc[31:LINE_OFFSET_BITS]);

    assign cur_line = lb_hit ? lb_line : resp_line_i;
    assign cur_word = cur_line[pc[LINE_OFFSET_BITS-1:2] * $bits(word_t) +: $bits(word_t)];

    assign enq_o   = (lb_hit || resp_hit) && !iq_full_i && !redirect_i;
    assign flush_o = redirect_i;
    assign req_o   = (state == WAIT_RESP);

    always_comb begin
        enq_pkt_o.order = order;
        enq_pkt_o.pc    = pc;
        enq_pkt_o.inst  = cur_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            pc       <= RESET_PC;
            order    <= '0;
            lb_valid <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (enq_o) begin
                pc    <= pc + 32'd4;
                order <= order + 64'd1;
            end

            case (state)
                IDLE: begin
                    if (!lb_hit && !redirect_i) begin
                        state <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    if (resp_i) begin
                        state    <= IDLE;
                        lb_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request address follows pc while idle, held while waiting
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_addr_o <= pc;
        end
        if ((state == WAIT_RESP) && resp_i) begin
            lb_line <= resp_line_i;
            lb_addr <= req_addr_o;
        end
    end

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache
import rv32i_types::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  req_i,
    input  addr_t req_addr_i,
    output logic  resp_o,
    output line_t resp_line_o,

    output logic  refill_req_o,
    output addr_t refill_addr_o,
    input  logic  refill_done_i,
    input  line_t refill_line_i
);

    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        RESPOND
    } cache_state_e;

    cache_state_e state;

    logic [ICACHE_SETS-1:0] valid_arr;
    tag_t                   tag_arr  [ICACHE_SETS];
    line_t                  data_arr [ICACHE_SETS];

    set_idx_t req_idx;
    tag_t     req_tag;
    set_idx_t fill_idx;
    logic     hit;

    assign req_idx  = req_addr_i[LINE_OFFSET_BITS +: SET_IDX_BITS];
    assign req_tag  = req_addr_i[31 -: TAG_BITS];
    assign fill_idx = refill_addr_o[LINE_OFFSET_BITS +: SET_IDX_BITS];

    assign hit = valid_arr[req_idx] && (tag_arr[req_idx] == req_tag);

    assign resp_o       = (state == RESPOND);
    assign refill_req_o = (state == REFILL);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= LOOKUP;
            valid_arr <= '0;
        end else begin
            case (state)
                LOOKUP: begin
                    if (req_i) begin
                        state <= hit ? RESPOND : REFILL;
                    end
                end
                REFILL: begin
                    if (refill_done_i) begin
                        valid_arr[fill_idx] <= 1'b1;
                        state               <= RESPOND;
                    end
                end
                RESPOND: state <= LOOKUP;
                default: state <= LOOKUP;
            endcase
        end
    end

    // arrays and response line
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && req_i) begin
            resp_line_o   <= data_arr[req_idx];
            refill_addr_o <= {req_addr_i[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
        if ((state == REFILL) && refill_done_i) begin
            tag_arr[fill_idx]  <= refill_addr_o[31 -: TAG_BITS];
            data_arr[fill_idx] <= refill_line_i;
            resp_line_o        <= refill_line_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/burst_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

module burst_deserializer
import rv32i_types::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  refill_req_i,
    input  addr_t refill_addr_i,
    output logic  refill_done_o,
    output line_t refill_line_o,

    input  logic  bmem_ready_i,
    input  addr_t bmem_raddr_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,
    output addr_t bmem_addr_o,
    output logic  bmem_read_o
);

    typedef enum logic [1:0] {
        DS_IDLE,
        DS_ISSUE,
        DS_BEATS,
        DS_DONE
    } ds_state_e;

    ds_state_e state;
    beat_idx_t beat_cnt;
    beat_idx_t beat_off;
    logic      beat_ok;

    // only beats of the pending line are taken
    assign beat_ok  = (state == DS_BEATS) && bmem_rvalid_i &&
        (bmem_raddr_i[31:LINE_OFFSET_BITS] == bmem_addr_o[31:LINE_OFFSET_BITS]);
    assign beat_off = bmem_raddr_i[BEAT_BYTE_BITS +: BEAT_IDX_BITS];

    assign bmem_read_o   = (state == DS_ISSUE) && bmem_ready_i;
    assign refill_done_o = (state == DS_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DS_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                DS_IDLE: begin
                    if (refill_req_i) begin
                        state <= DS_ISSUE;
                    end
                end
                DS_ISSUE: begin
                    if (bmem_ready_i) begin
                        state    <= DS_BEATS;
                        beat_cnt <= '0;
                    end
                end
                DS_BEATS: begin
                    if (beat_ok) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                            state <= DS_DONE;
                        end
                    end
                end
                DS_DONE: state <= DS_IDLE;
                default: state <= DS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == DS_IDLE) && refill_req_i) begin
            bmem_addr_o <= {refill_addr_i[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
        if (beat_ok) begin
            refill_line_o[beat_off * $bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/inst_queue.sv
`timescale 1ns/100ps
`default_nettype none

module inst_queue
import rv32i_types::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_i,

    input  logic       enq_i,
    input  fetch_pkt_t enq_pkt_i,
    output logic       full_o,

    input  logic       deq_i,
    output fetch_pkt_t head_pkt_o,
    output logic       empty_o
);

    fetch_pkt_t mem [IQ_DEPTH];

    iq_ptr_t              head;
    iq_ptr_t              tail;
    logic [IQ_PTR_BITS:0] count;

    logic do_enq;
    logic do_deq;

    assign full_o  = (count == (IQ_PTR_BITS + 1)'(IQ_DEPTH));
    assign empty_o = (count == '0);

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_i && !empty_o;

    // head entry is visible without a read strobe
    assign head_pkt_o = mem[head];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= tail + 1'b1;
            end
            if (do_deq) begin
                head <= head + 1'b1;
            end
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[tail] <= enq_pkt_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode
import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush_i,
    input  logic         stall_i,

    input  logic         empty_i,
    input  fetch_pkt_t   head_pkt_i,
    output logic         deq_o,

    output logic         id_valid_o,
    output decoded_pkt_t id_pkt_o
);

    opcode_e      opcode;
    word_t        inst;
    decoded_pkt_t dec;

    assign inst   = head_pkt_i.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign deq_o  = !empty_i && !stall_i;

    always_comb begin
        dec.order = head_pkt_i.order;
        dec.pc    = head_pkt_i.pc;
        dec.inst  = inst;
        dec.rd    = inst[11:7];
        dec.rs1   = inst[19:15];
        dec.rs2   = inst[24:20];
        dec.rd_we = 1'b1;
        dec.imm   = '0;

        case (opcode)
            op_b_lui, op_b_auipc, op_b_imm, op_b_reg: dec.op_class = class_alu;
            op_b_br, op_b_jal, op_b_jalr:             dec.op_class = class_br;
            op_b_load, op_b_store:                    dec.op_class = class_mem;
            default:                                  dec.op_class = class_none;
        endcase

        // immediate by format
        case (opcode)
            op_b_jalr, op_b_load, op_b_imm: begin
                dec.imm = {{20{inst[31]}}, inst[31:20]};
            end
            op_b_store: begin
                dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_b_br: begin
                dec.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            op_b_lui, op_b_auipc: begin
                dec.imm = {inst[31:12], 12'h000};
            end
            op_b_jal: begin
                dec.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: dec.imm = '0;
        endcase

        // branches without link and stores write nothing
        if ((opcode == op_b_br) || (opcode == op_b_store) || (dec.rd == '0)) begin
            dec.rd_we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            id_valid_o <= 1'b0;
        end else if (!stall_i) begin
            id_valid_o <= deq_o;
        end
    end

    always_ff @(posedge clk) begin
        if (deq_o) begin
            id_pkt_o <= dec;
        end
    end

endmodule

`default_nettype wire

// File: hdl/frontend_top.sv
`timescale 1ns/100ps
`default_nettype none

module frontend_top
import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,

    output addr_t        bmem_addr_o,
    output logic         bmem_read_o,
    input  logic         bmem_ready_i,
    input  addr_t        bmem_raddr_i,
    input  beat_t        bmem_rdata_i,
    input  logic         bmem_rvalid_i,

    input  logic         redirect_i,
    input  addr_t        redirect_pc_i,
    input  logic         stall_i,

    output logic         id_valid_o,
    output decoded_pkt_t id_pkt_o
);

    // fetch to cache
    logic       req;
    addr_t      req_addr;
    logic       resp;
    line_t      resp_line;

    // cache to deserializer
    logic       refill_req;
    addr_t      refill_addr;
    logic       refill_done;
    line_t      refill_line;

    // queue
    logic       flush;
    logic       enq;
    fetch_pkt_t enq_pkt;
    logic       iq_full;
    logic       deq;
    fetch_pkt_t head_pkt;
    logic       iq_empty;

    fetch_ctrl fetch_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .resp_i        (resp),
        .resp_line_i   (resp_line),
        .req_o         (req),
        .req_addr_o    (req_addr),
        .iq_full_i     (iq_full),
        .enq_o         (enq),
        .enq_pkt_o     (enq_pkt),
        .flush_o       (flush)
    );

    icache icache_i (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req),
        .req_addr_i    (req_addr),
        .resp_o        (resp),
        .resp_line_o   (resp_line),
        .refill_req_o  (refill_req),
        .refill_addr_o (refill_addr),
        .refill_done_i (refill_done),
        .refill_line_i (refill_line)
    );

    burst_deserializer deser_i (
        .clk           (clk),
        .rst           (rst),
        .refill_req_i  (refill_req),
        .refill_addr_i (refill_addr),
        .refill_done_o (refill_done),
        .refill_line_o (refill_line),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o)
    );

    inst_queue inst_queue_i (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush),
        .enq_i      (enq),
        .enq_pkt_i  (enq_pkt),
        .full_o     (iq_full),
        .deq_i      (deq),
        .head_pkt_o (head_pkt),
        .empty_o    (iq_empty)
    );

    decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .flush_i    (flush),
        .stall_i    (stall_i),
        .empty_i    (iq_empty),
        .head_pkt_i (head_pkt),
        .deq_o      (deq),
        .id_valid_o (id_valid_o),
        .id_pkt_o   (id_pkt_o)
    );

endmodule

`default_nettype wire

// File: tb/bmem_model.sv
`timescale 1ns/100ps
`default_nettype none

module bmem_model
import rv32i_types::*;
#(
    parameter int PROG_WORDS = 24
)
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t bmem_addr_i,
    input  logic  bmem_read_i,
    output logic  bmem_ready_o,
    output addr_t bmem_raddr_o,
    output beat_t bmem_rdata_o,
    output logic  bmem_rvalid_o
);

    localparam int PROG_LINES = (PROG_WORDS * 4 + 31) / 32;

    // program words that the testbench writes before reset ends
    word_t prog [PROG_WORDS];
    int    line_reads [PROG_LINES];
    int    read_count;

    logic  busy;
    int    wait_cnt;
    int    beat;
    addr_t base;
    logic  rst_seen;
    logic  read_seen;
    addr_t addr_seen;

    function automatic word_t word_at(input addr_t a);
        int idx;
        idx = int'((a - RESET_PC) >> 2);
        if ((a >= RESET_PC) && (idx < PROG_WORDS)) begin
            return prog[idx];
        end
        // outside the program every word depends on its full address
        return a ^ 32'h5a5a_5a5a;
    endfunction

    task automatic count_line(input addr_t a);
        int line;
        line = int'((a - RESET_PC) >> 5);
        if ((a >= RESET_PC) && (line < PROG_LINES)) begin
            line_reads[line]++;
        end
    endtask

    initial begin
        bmem_ready_o  = 1'b1;
        bmem_rvalid_o = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        busy          = 1'b0;
        wait_cnt      = 0;
        beat          = 0;
        base          = '0;
        read_count    = 0;
        for (int k = 0; k < PROG_LINES; k++) begin
            line_reads[k] = 0;
        end
    end

    always @(posedge clk) begin
        rst_seen  = rst;
        read_seen = bmem_read_i;
        addr_seen = bmem_addr_i;
        #2;
        bmem_rvalid_o = 1'b0;
        if (rst_seen) begin
            busy         = 1'b0;
            bmem_ready_o = 1'b1;
        end else if (!busy) begin
            if (read_seen) begin
                busy         = 1'b1;
                bmem_ready_o = 1'b0;
                wait_cnt     = 2 + int'($urandom % 8);
                beat         = 0;
                base         = addr_seen;
                read_count++;
                count_line(addr_seen);
            end
        end else if (wait_cnt > 0) begin
            wait_cnt--;
        // about one cycle in four leaves a gap between beats
        end else if ($urandom % 4 != 0) begin
            bmem_rvalid_o = 1'b1;
            bmem_raddr_o  = base + addr_t'(8 * beat);
            bmem_rdata_o  = {word_at(bmem_raddr_o + 32'd4), word_at(bmem_raddr_o)};
            beat++;
            if (beat == BEATS_PER_LINE) begin
                busy         = 1'b0;
                bmem_ready_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module tb_frontend
import rv32i_types::*;
();

    localparam int N_ENTRIES   = 24;
    localparam int N_PASSES    = 3;
    localparam int PROG_LINES  = 3;
    localparam int CLK_PERIOD  = 20;
    localparam int WATCHDOG_NS = 200 * N_ENTRIES * N_PASSES * CLK_PERIOD;

    logic         clk;
    logic         rst;
    addr_t        bmem_addr;
    logic         bmem_read;
    logic         bmem_ready;
    addr_t        bmem_raddr;
    beat_t        bmem_rdata;
    logic         bmem_rvalid;
    logic         redirect;
    addr_t        redirect_pc;
    logic         stall;
    logic         id_valid;
    decoded_pkt_t id_pkt;

    // program and expected decode
    word_t     tbl_inst  [N_ENTRIES];
    op_class_e tbl_class [N_ENTRIES];
    reg_idx_t  tbl_rd    [N_ENTRIES];
    reg_idx_t  tbl_rs1   [N_ENTRIES];
    reg_idx_t  tbl_rs2   [N_ENTRIES];
    word_t     tbl_imm   [N_ENTRIES];
    logic      tbl_we    [N_ENTRIES];

    int           errors;
    int           checks;
    int           tests;
    int           long_stall;
    order_t       last_order;
    logic         seen_any;
    logic         hold_prev;
    decoded_pkt_t prev_pkt;

    frontend_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall),
        .id_valid_o    (id_valid),
        .id_pkt_o      (id_pkt)
    );

    bmem_model #(.PROG_WORDS(N_ENTRIES)) mem_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic set_entry(input int i, input word_t inst, input op_class_e cls,
                             input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                             input word_t imm, input logic we);
        tbl_inst[i]  = inst;
        tbl_class[i] = cls;
        tbl_rd[i]    = rd;
        tbl_rs1[i]   = rs1;
        tbl_rs2[i]   = rs2;
        tbl_imm[i]   = imm;
        tbl_we[i]    = we;
    endtask

    task automatic load_table();
        set_entry(0,  32'h003100B3, class_alu,  1,  2,  3,  32'h00000000, 1'b1); // add
        set_entry(1,  32'h407302B3, class_alu,  5,  6,  7,  32'h00000000, 1'b1); // sub
        set_entry(2,  32'h00000013, class_alu,  0,  0,  0,  32'h00000000, 1'b0); // nop
        set_entry(3,  32'hFFF58513, class_alu,  10, 11, 31, 32'hFFFFFFFF, 1'b1); // addi -1
        set_entry(4,  32'h07F27213, class_alu,  4,  4,  31, 32'h0000007F, 1'b1); // andi
        set_entry(5,  32'h123451B7, class_alu,  3,  8,  3,  32'h12345000, 1'b1); // lui
        set_entry(6,  32'h00001017, class_alu,  0,  0,  0,  32'h00001000, 1'b0); // auipc x0
        set_entry(7,  32'h01012403, class_mem,  8,  2,  16, 32'h00000010, 1'b1); // lw
        set_entry(8,  32'hFFC08483, class_mem,  9,  1,  28, 32'hFFFFFFFC, 1'b1); // lb
        set_entry(9,  32'h00512423, class_mem,  8,  2,  5,  32'h00000008, 1'b0); // sw
        set_entry(10, 32'hFE638FA3, class_mem,  31, 7,  6,  32'hFFFFFFFF, 1'b0); // sb
        set_entry(11, 32'h00208463, class_br,   8,  1,  2,  32'h00000008, 1'b0); // beq
        set_entry(12, 32'hFE419EE3, class_br,   29, 3,  4,  32'hFFFFFFFC, 1'b0); // bne
        set_entry(13, 32'h010000EF, class_br,   1,  0,  16, 32'h00000010, 1'b1); // jal
        set_entry(14, 32'hFF9FF06F, class_br,   0,  31, 25, 32'hFFFFFFF8, 1'b0); // jal x0
        set_entry(15, 32'h000280E7, class_br,   1,  5,  0,  32'h00000000, 1'b1); // jalr
        set_entry(16, 32'hFF408067, class_br,   0,  1,  20, 32'hFFFFFFF4, 1'b0); // jalr x0
        set_entry(17, 32'h01DF6FB3, class_alu,  31, 30, 29, 32'h00000000, 1'b1); // or
        set_entry(18, 32'h5556C613, class_alu,  12, 13, 21, 32'h00000555, 1'b1); // xori
        set_entry(19, 32'h0000000F, class_none, 0,  0,  0,  32'h00000000, 1'b0); // fence
        set_entry(20, 32'h34011173, class_none, 2,  2,  0,  32'h00000000, 1'b1); // csrrw
        set_entry(21, 32'h7FF75783, class_mem,  15, 14, 31, 32'h000007FF, 1'b1); // lhu
        set_entry(22, 32'h80947063, class_br,   0,  8,  9,  32'hFFFFF000, 1'b0); // bgeu
        set_entry(23, 32'hFFFFFA17, class_alu,  20, 31, 31, 32'hFFFFF000, 1'b1); // auipc
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_packet(input int pass, input int idx);
        string tag;
        tag = $sformatf("pass%0d entry %0d", pass, idx);
        check_value({tag, " pc"}, RESET_PC + addr_t'(4 * idx), id_pkt.pc);
        if (!seen_any) begin
            check_value({tag, " order"}, 64'd0, id_pkt.order);
        end else if (idx == 0) begin
            // after a redirect the order only has to move forward
            check_value({tag, " order advances"}, 64'd1, 64'(id_pkt.order > last_order));
        end else begin
            check_value({tag, " order"}, last_order + 64'd1, id_pkt.order);
        end
        seen_any   = 1'b1;
        last_order = id_pkt.order;
        check_value({tag, " inst"}, tbl_inst[idx], id_pkt.inst);
        check_value({tag, " class"}, 64'(tbl_class[idx]), 64'(id_pkt.op_class));
        check_value({tag, " rd"}, tbl_rd[idx], id_pkt.rd);
        check_value({tag, " rs1"}, tbl_rs1[idx], id_pkt.rs1);
        check_value({tag, " rs2"}, tbl_rs2[idx], id_pkt.rs2);
        check_value({tag, " imm"}, tbl_imm[idx], id_pkt.imm);
        check_value({tag, " rd_we"}, tbl_we[idx], id_pkt.rd_we);
    endtask

    // output must not move while the back end stalls
    task automatic check_hold();
        if (hold_prev) begin
            check_value("stall hold valid", 64'd1, 64'(id_valid));
            check_value("stall hold packet", 64'd1, 64'(id_pkt == prev_pkt));
        end
        hold_prev = id_valid && stall && !redirect;
        prev_pkt  = id_pkt;
    endtask

    task automatic run_pass(input int pass, input int stop_at);
        int idx;
        int start_errors;
        idx          = 0;
        start_errors = errors;
        while (idx < stop_at) begin
            @(negedge clk);
            check_hold();
            if (id_valid && !stall) begin
                check_packet(pass, idx);
                idx++;
                // long stall lets the queue fill up
                if ((pass == 0) && (idx == 6)) begin
                    long_stall = 40;
                end
            end
            @(posedge clk);
            #2;
            if (idx >= stop_at) begin
                stall = 1'b1;
            end else if (long_stall > 0) begin
                stall = 1'b1;
                long_stall--;
            end else begin
                stall = ($urandom % 4 == 0);
            end
        end
        tests++;
        $display("test pass%0d (%0d entries): %0d errors", pass, stop_at,
                 errors - start_errors);
    endtask

    task automatic redirect_to(input addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        stall       = 1'b1;
        @(posedge clk);
        #2;
        redirect    = 1'b0;
    endtask

    task automatic check_refills(input string name);
        int start_errors;
        start_errors = errors;
        for (int k = 0; k < PROG_LINES; k++) begin
            check_value($sformatf("%s line %0d reads", name, k), 64'd1,
                        64'(mem_i.line_reads[k]));
        end
        tests++;
        $display("test %s: %0d errors, %0d reads in total", name,
                 errors - start_errors, mem_i.read_count);
    endtask

    initial begin
        void'($urandom(80741));
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = RESET_PC;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        long_stall  = 0;
        last_order  = '0;
        seen_any    = 1'b0;
        hold_prev   = 1'b0;
        prev_pkt    = '0;
        load_table();
        for (int i = 0; i < N_ENTRIES; i++) begin
            mem_i.prog[i] = tbl_inst[i];
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        run_pass(0, N_ENTRIES);
        check_refills("first pass refills");
        redirect_to(RESET_PC);
        // second pass is cut short by another redirect
        run_pass(1, N_ENTRIES / 2);
        redirect_to(RESET_PC);
        run_pass(2, N_ENTRIES);
        check_refills("refills after cached passes");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the packets did not all arrive in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/rv32i_types.sv
hdl/fetch_ctrl.sv
hdl/icache.sv
hdl/burst_deserializer.sv
hdl/inst_queue.sv
hdl/decode.sv
hdl/frontend_top.sv
tb/bmem_model.sv
tb/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f filelist.f \
    --top-module tb_frontend \
    -o sim_frontend

./obj_dir/sim_frontend | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
